// ==== common/taylor_pkg.sv ====
package taylor_pkg;

	// Argument x, signed Q1.18
	localparam int X_W = 19;
	localparam int FRAC_BITS = 18;

	// Accumulator and result, signed Q4.24
	localparam int Y_W = 28;

	// Result sequence number
	localparam int TAG_W = 4;

	// exp(x) terms, index 0 is c0
	localparam logic [3:0][Y_W-1:0] TAYLOR_COEF = {
		28'h02AAAAB, // 1/6
		28'h0800000, // 1/2
		28'h1000000, // 1
		28'h1000000  // 1
	};

	// Wishbone register map
	localparam logic [1:0] ADR_ARG = 2'd0;
	localparam logic [1:0] ADR_RESULT = 2'd1;
	localparam logic [1:0] ADR_STATUS = 2'd2;

endpackage

// ==== source/core_wakeup.sv ====
`timescale 1ns/1ps

module core_wakeup #(
	parameter int N_CORES = 6,
	parameter int WAKE_GAP = 7
) (
	input  logic               clk,
	input  logic               arst_n,
	output logic [N_CORES-1:0] awake,
	output logic [7:0]         awake_count
);
	localparam int IDX_W = $clog2(N_CORES + 1);
	localparam int GAP_W = $clog2(WAKE_GAP + 1);

	logic [IDX_W-1:0] idx; // Next core to wake
	logic [GAP_W-1:0] gap_cnt;
	logic all_awake;

	assign all_awake = idx == IDX_W'(N_CORES);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			awake <= '0;
			awake_count <= 8'd0;
			idx <= '0;
			gap_cnt <= '0;
		end else if (!all_awake) begin
			if (gap_cnt == GAP_W'(WAKE_GAP - 1)) begin
				gap_cnt <= '0;
				awake[idx] <= 1'b1;
				idx <= idx + 1'b1;
				awake_count <= awake_count + 8'd1;
			end else
				gap_cnt <= gap_cnt + 1'b1;
		end
	end

endmodule

// ==== source/host_port.sv ====
`timescale 1ns/1ps

module host_port import taylor_pkg::*; #(
	parameter int N_CORES = 6
) (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          cyc,
	input  logic                          stb,
	input  logic                          we,
	input  logic [1:0]                    adr,
	input  logic [31:0]                   dat_w,
	output logic [31:0]                   dat_r,
	output logic                          ack,
	input  logic [N_CORES-1:0]            core_ready,
	output logic [N_CORES-1:0]            core_start,
	output logic [N_CORES-1:0][X_W-1:0]   core_arg,
	output logic [N_CORES-1:0][TAG_W-1:0] core_tag,
	input  logic                          fifo_valid,
	input  logic [TAG_W+Y_W-1:0]          fifo_data,
	input  logic [7:0]                    fifo_level,
	input  logic [7:0]                    awake_count,
	output logic                          pop
);
	localparam int CORE_W = N_CORES > 1 ? $clog2(N_CORES) : 1;

	logic [CORE_W-1:0] ring;
	logic [TAG_W-1:0] tag_cnt;
	logic [X_W-1:0] arg_q;
	logic [TAG_W-1:0] tag_q;
	logic req, arg_wr, res_rd, can_ack, fire;
	logic [31:0] rd_data;

	assign req = cyc && stb && !ack; // Ack cycle closes the transfer
	assign arg_wr = we && adr == ADR_ARG;
	assign res_rd = !we && adr == ADR_RESULT;

	always_comb begin
		if (arg_wr)
			can_ack = core_ready[ring];
		else if (res_rd)
			can_ack = fifo_valid;
		else
			can_ack = 1'b1;
	end

	assign fire = req && can_ack;

	always_comb begin
		rd_data = '0;
		case (adr)
			ADR_RESULT: begin
				rd_data[31 -: TAG_W] = fifo_data[TAG_W+Y_W-1 -: TAG_W];
				rd_data[Y_W-1:0] = fifo_data[Y_W-1:0];
			end
			ADR_STATUS: rd_data = {16'd0, awake_count, fifo_level};
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
			pop <= 1'b0;
			core_start <= '0;
			ring <= '0;
			tag_cnt <= '0;
		end else begin
			ack <= fire;
			pop <= fire && res_rd;
			core_start <= '0;
			if (fire && arg_wr) begin
				core_start[ring] <= 1'b1;
				ring <= (ring == CORE_W'(N_CORES - 1)) ? '0 : ring + 1'b1;
				tag_cnt <= tag_cnt + 1'b1; // Wraps at 2^TAG_W
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire && arg_wr) begin
			arg_q <= dat_w[X_W-1:0];
			tag_q <= tag_cnt;
		end
		if (fire && !we)
			dat_r <= rd_data;
	end

	// Only the started core samples these
	assign core_arg = {N_CORES{arg_q}};
	assign core_tag = {N_CORES{tag_q}};

endmodule

// ==== taylor_core/taylor_core.sv ====
`timescale 1ns/1ps

module taylor_core import taylor_pkg::*; (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             awake,
	input  logic             start,
	input  logic [X_W-1:0]   arg,
	input  logic [TAG_W-1:0] tag_in,
	input  logic             take,
	output logic             ready,
	output logic             done,
	output logic [Y_W-1:0]   y,
	output logic [TAG_W-1:0] tag_out
);
	logic busy;
	logic [1:0] step;
	logic [1:0] coef_sel;
	logic signed [Y_W-1:0] acc;
	logic signed [X_W-1:0] x;
	logic signed [X_W+Y_W-1:0] prod;
	logic [Y_W-1:0] mac;

	// Horner step: acc*x in Q.42, back to Q.24, plus next term
	assign prod = acc * x;
	assign coef_sel = 2'd2 - step;
	assign mac = Y_W'(prod >>> FRAC_BITS) + TAYLOR_COEF[coef_sel];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			ready <= 1'b0;
			step <= '0;
		end else if (!awake) begin // Asleep, held in reset
			busy <= 1'b0;
			done <= 1'b0;
			ready <= 1'b0;
			step <= '0;
		end else if (start) begin
			busy <= 1'b1;
			ready <= 1'b0;
			step <= '0;
		end else if (busy) begin
			step <= step + 2'd1;
			if (step == 2'd2) begin // c0 term added this cycle
				busy <= 1'b0;
				done <= 1'b1;
			end
		end else if (done) begin
			if (take) begin
				done <= 1'b0;
				ready <= 1'b1;
			end
		end else
			ready <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (start) begin
			acc <= TAYLOR_COEF[3];
			x <= arg;
			tag_out <= tag_in;
		end else if (busy)
			acc <= mac;
	end

	assign y = acc;

endmodule

// ==== source/result_collector.sv ====
`timescale 1ns/1ps

module result_collector import taylor_pkg::*; #(
	parameter int N_CORES = 6,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [N_CORES-1:0]            done,
	input  logic [N_CORES-1:0][Y_W-1:0]   y,
	input  logic [N_CORES-1:0][TAG_W-1:0] tag,
	output logic [N_CORES-1:0]            take,
	input  logic                          pop,
	output logic                          fifo_valid,
	output logic [TAG_W+Y_W-1:0]          fifo_data,
	output logic [7:0]                    fifo_level
);
	localparam int CORE_W = N_CORES > 1 ? $clog2(N_CORES) : 1;
	localparam int PTR_W = FIFO_DEPTH > 1 ? $clog2(FIFO_DEPTH) : 1;

	logic [TAG_W+Y_W-1:0] mem [FIFO_DEPTH];
	logic [CORE_W-1:0] drain; // Ring position of the next result
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [7:0] count;
	logic full, push, pull;

	assign full = count == 8'(FIFO_DEPTH);
	assign push = done[drain] && !full;
	assign pull = pop && fifo_valid;

	always_comb begin
		take = '0;
		take[drain] = push;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			drain <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= 8'd0;
		end else begin
			if (push) begin
				drain <= (drain == CORE_W'(N_CORES - 1)) ? '0 : drain + 1'b1;
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pull)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + {7'd0, push} - {7'd0, pull};
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= {tag[drain], y[drain]};
	end

	assign fifo_valid = count != 8'd0;
	assign fifo_data = mem[rd_ptr];
	assign fifo_level = count;

endmodule

// ==== source/taylor_top.sv ====
`timescale 1ns/1ps

module taylor_top import taylor_pkg::*; #(
	parameter int N_CORES = 6,
	parameter int WAKE_GAP = 7,
	parameter int FIFO_DEPTH = 4
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [1:0]  adr,
	input  logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic        ack
);
	logic [N_CORES-1:0] awake;
	logic [7:0] awake_count;

	logic [N_CORES-1:0] core_ready;
	logic [N_CORES-1:0] core_start;
	logic [N_CORES-1:0][X_W-1:0] core_arg;
	logic [N_CORES-1:0][TAG_W-1:0] core_tag;
	logic [N_CORES-1:0] core_done;
	logic [N_CORES-1:0][Y_W-1:0] core_y;
	logic [N_CORES-1:0][TAG_W-1:0] core_tag_out;
	logic [N_CORES-1:0] take;

	logic fifo_valid;
	logic [TAG_W+Y_W-1:0] fifo_data;
	logic [7:0] fifo_level;
	logic pop;

	core_wakeup #(
		.N_CORES  (N_CORES),
		.WAKE_GAP (WAKE_GAP)
	) u_wakeup (
		.clk         (clk),
		.arst_n      (arst_n),
		.awake       (awake),
		.awake_count (awake_count)
	);

	host_port #(
		.N_CORES (N_CORES)
	) u_host (
		.clk         (clk),
		.arst_n      (arst_n),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.dat_w       (dat_w),
		.dat_r       (dat_r),
		.ack         (ack),
		.core_ready  (core_ready),
		.core_start  (core_start),
		.core_arg    (core_arg),
		.core_tag    (core_tag),
		.fifo_valid  (fifo_valid),
		.fifo_data   (fifo_data),
		.fifo_level  (fifo_level),
		.awake_count (awake_count),
		.pop         (pop)
	);

	for (genvar i = 0; i < N_CORES; i++) begin : g_core
		taylor_core u_core (
			.clk     (clk),
			.arst_n  (arst_n),
			.awake   (awake[i]),
			.start   (core_start[i]),
			.arg     (core_arg[i]),
			.tag_in  (core_tag[i]),
			.take    (take[i]),
			.ready   (core_ready[i]),
			.done    (core_done[i]),
			.y       (core_y[i]),
			.tag_out (core_tag_out[i])
		);
	end

	result_collector #(
		.N_CORES    (N_CORES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_collect (
		.clk        (clk),
		.arst_n     (arst_n),
		.done       (core_done),
		.y          (core_y),
		.tag        (core_tag_out),
		.take       (take),
		.pop        (pop),
		.fifo_valid (fifo_valid),
		.fifo_data  (fifo_data),
		.fifo_level (fifo_level)
	);

endmodule

// ==== tb/taylor_assert.sv ====
`timescale 1ns/1ps

module taylor_assert #(
	parameter bit BUS_SIDE = 1'b1
) (
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic full,
	input logic pull
);

	if (BUS_SIDE) begin : g_bus
		ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
			ack |-> cyc && stb)
			else $error("ack without cyc and stb");

		ack_single: assert property (@(posedge clk) disable iff (!arst_n)
			ack |=> !ack)
			else $error("ack high two cycles in a row");

		ack_reset: assert property (@(posedge clk) !arst_n |-> !ack)
			else $error("ack during reset");
	end else begin : g_fifo
		// Count past the depth means a push went in while full
		no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
			full && !pull |=> full)
			else $error("push into full FIFO");
	end

endmodule

bind host_port taylor_assert #(.BUS_SIDE (1'b1)) u_bus_chk (
	.clk    (clk),
	.arst_n (arst_n),
	.cyc    (cyc),
	.stb    (stb),
	.ack    (ack),
	.full   (1'b0),
	.pull   (pop)
);

bind result_collector taylor_assert #(.BUS_SIDE (1'b0)) u_fifo_chk (
	.clk    (clk),
	.arst_n (arst_n),
	.cyc    (1'b0),
	.stb    (1'b0),
	.ack    (1'b0),
	.full   (full),
	.pull   (pull)
);

// ==== tb/taylor_tb.sv ====
`timescale 1ns/1ps

module taylor_tb;
	localparam int N_CORES = 6;
	localparam int WAKE_GAP = 7;
	localparam int FIFO_DEPTH = 4;
	localparam int MAX_VEC = 64;
	localparam int ACK_LIMIT = 200;

	logic clk, arst_n, cyc, stb, we, ack;
	logic [1:0] adr;
	logic [31:0] dat_w, dat_r;

	// op[71:68] adr[67:64] data[63:32] expected[31:0]
	logic [71:0] vec [MAX_VEC];
	int n_vec;
	int errors;
	logic [31:0] lfsr;

	taylor_top #(
		.N_CORES    (N_CORES),
		.WAKE_GAP   (WAKE_GAP),
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut (
		.clk    (clk),
		.arst_n (arst_n),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.adr    (adr),
		.dat_w  (dat_w),
		.dat_r  (dat_r),
		.ack    (ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = b ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		return b;
	endfunction

	// One bus transfer with ack timeout
	task automatic bus_xfer(input logic wr, input logic [1:0] a, input logic [31:0] d,
			input int limit, output logic got_ack, output logic [31:0] rd);
		int n;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr <= a;
		dat_w <= d;
		got_ack = 1'b0;
		rd = '0;
		for (n = 0; n < limit && !got_ack; n++) begin
			@(negedge clk);
			if (ack) begin
				got_ack = 1'b1;
				rd = dat_r;
			end
		end
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	initial begin
		int i;
		int gap;
		int prev_awake;
		logic [3:0] op;
		logic got;
		logic [31:0] rd;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		arst_n = 1'b0;
		errors = 0;
		prev_awake = 0;
		lfsr = 32'h79dae615;
		for (i = 0; i < MAX_VEC; i++)
			vec[i] = {4'hF, 68'(i)}; // Op F marks the end
		$readmemh("tb/taylor_vectors.txt", vec);
		n_vec = 0;
		while (n_vec < MAX_VEC && vec[n_vec][71:68] != 4'hF)
			n_vec++;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		for (i = 0; i < n_vec; i++) begin
			op = vec[i][71:68];
			gap = {lfsr_bit(), lfsr_bit()};
			repeat (gap) @(posedge clk); // Random idle between transfers
			case (op)
				4'd0: repeat (vec[i][63:32]) @(posedge clk);
				4'd4: begin // Write that must be held off
					bus_xfer(1'b1, vec[i][65:64], vec[i][63:32], 50, got, rd);
					if (got) begin
						$display("Fail %0t: line %0d write acked while FIFO full", $time, i);
						errors++;
					end
				end
				default: begin
					bus_xfer(op == 4'd1, vec[i][65:64], vec[i][63:32], ACK_LIMIT, got, rd);
					if (!got) begin
						$display("No ack on bus for vector line %0d", i);
						errors++;
					end else if (op == 4'd2) begin
						if (rd !== vec[i][31:0]) begin
							$display("Fail %0t: line %0d read %h, expected %h",
								$time, i, rd, vec[i][31:0]);
							errors++;
						end
					end else if (op == 4'd3) begin
						if (int'(rd[15:8]) < prev_awake || rd[15:8] > 8'(N_CORES)) begin
							$display("Fail %0t: awake count %0d after %0d",
								$time, rd[15:8], prev_awake);
							errors++;
						end
						prev_awake = int'(rd[15:8]);
					end
				end
			endcase
		end

		repeat (4) @(posedge clk);
		$display("Vectors: %0d, errors: %0d", n_vec, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#1;
		repeat (n_vec * ACK_LIMIT + N_CORES * WAKE_GAP + 8) @(posedge clk);
		$display("Simulation ran past its time limit");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb/taylor_vectors.txt ====
// op_adr_data_expected; op 0 idle (data = cycles), 1 write, 2 read and compare,
// 3 status read with rising awake count, 4 write that must stall
3_2_00000000_00000000
3_2_00000000_00000000
3_2_00000000_00000000
3_2_00000000_00000000
3_2_00000000_00000000
3_2_00000000_00000000
0_0_00000028_00000000
2_2_00000000_00000600
1_0_00000000_00000000
2_1_00000000_01000000
1_0_00020000_00000000
2_1_00000000_11A55555
1_0_00060000_00000000
2_1_00000000_209AAAAA
1_0_0003FFFF_00000000
2_1_00000000_32AAAA0A
1_0_00040001_00000000
2_1_00000000_40555574
1_0_00000001_00000000
2_1_00000000_51000040
1_0_0007FFFF_00000000
2_1_00000000_60FFFFC0
1_3_DEADBEEF_00000000
2_3_00000000_00000000
1_0_00000000_00000000
1_0_00000000_00000000
1_0_00000000_00000000
1_0_00000000_00000000
1_0_00000000_00000000
1_0_00000000_00000000
1_0_00000000_00000000
1_0_00000000_00000000
1_0_00000000_00000000
1_0_00000000_00000000
4_0_00000000_00000000
2_1_00000000_71000000
1_0_00000000_00000000
2_1_00000000_81000000
1_0_00000000_00000000
0_0_00000014_00000000
2_2_00000000_00000604
2_1_00000000_91000000
2_1_00000000_A1000000
2_1_00000000_B1000000
2_1_00000000_C1000000
2_1_00000000_D1000000
2_1_00000000_E1000000
2_1_00000000_F1000000
2_1_00000000_01000000
2_1_00000000_11000000
2_1_00000000_21000000

// ==== flist.f ====
common/taylor_pkg.sv
source/core_wakeup.sv
source/host_port.sv
taylor_core/taylor_core.sv
source/result_collector.sv
source/taylor_top.sv
tb/taylor_assert.sv
tb/taylor_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module taylor_tb \
	--Mdir obj_dir -o taylor_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/taylor_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "No result line in $LOG"
	exit 1
fi
exit 0
